/* rtl/conv_load_pkg.sv */
`default_nettype none

package conv_load_pkg;

  ////////////////////
  // tile geometry
  ////////////////////

  // one ddr word holds a row of 32 pixels, also the tile width
  localparam int PIXELS_IN_ROW = 32;
  localparam int PIXELS_IN_ROW_LOG2 = 5;
  // three row buffers, also the tile height
  localparam int BUFFERS_NUM = 3;
  // two input channels share one ddr word
  localparam int IFS_IN_ROW_LOG2 = 1;
  // output channels per chunk in mode 0 and mode 1
  localparam int ROW_NUM_MODE0 = 64;
  localparam int ROW_NUM_MODE1 = 128;
  // row buffer depth is 4096 words
  localparam int INPUT_BUFFER_SIZE_LOG2 = 12;

  ////////////////////
  // types
  ////////////////////

  typedef logic [15:0] idx_t;
  typedef logic [7:0] size_t;
  typedef logic [3:0] log2_t;
  // row buffer number runs 1 to 3
  typedef logic [1:0] buf_idx_t;

  // tile position class, also the index into the word and split tables
  typedef enum logic [1:0] {FIRST = 2'd0, MID = 2'd1, LAST = 2'd2} tile_class_e;

  // load info word for the downstream fifo
  typedef struct packed {
    buf_idx_t buf_idx;
    logic [29:0] buf_adr;
  } load_info_t;

endpackage

`default_nettype wire

/* rtl/conv_load_if.sv */
`default_nettype none

////////////////////
// layer configuration
////////////////////

interface layer_cfg_if import conv_load_pkg::*; ();
  idx_t row_num;
  idx_t of;
  idx_t ox;
  idx_t oy;
  idx_t nif;
  idx_t base_adr;
  // shift of one column word and of one input row
  log2_t col_shift;
  log2_t row_shift;
  // wraps the buffer row inside the buffer depth
  idx_t row_mask;
  // indexed by tile_class_e, split table as [y class][x class]
  size_t [2:0] ix_word_num;
  size_t [2:0] iy_row_num;
  size_t [2:0][2:0] split_size;
  idx_t ix_chunks_num;
  idx_t iy_chunks_num;

  modport src (output row_num, of, ox, oy, nif, base_adr, col_shift, row_shift, row_mask,
               ix_word_num, iy_row_num, split_size, ix_chunks_num, iy_chunks_num);
  modport dst (input row_num, of, ox, oy, nif, base_adr, col_shift, row_shift, row_mask,
               ix_word_num, iy_row_num, split_size, ix_chunks_num, iy_chunks_num);
endinterface

////////////////////
// term handshake
////////////////////

interface term_if import conv_load_pkg::*; ();
  logic start;
  idx_t chunk_words;
  size_t split_size;
  logic word_done;
  logic term_end;
  logic tile_end;

  modport seq (output start, chunk_words, split_size, input word_done, term_end, tile_end);
  modport fetch (input start, chunk_words, split_size, output word_done, term_end, tile_end);
endinterface

////////////////////
// fetch position
////////////////////

interface fetch_pos_if import conv_load_pkg::*; ();
  logic read_en;
  idx_t row_idx;
  idx_t col_idx;
  idx_t if_start;
  buf_idx_t buf_idx;
  idx_t buf_row;

  modport src (output read_en, row_idx, col_idx, if_start, buf_idx, buf_row);
  modport dst (input read_en, row_idx, col_idx, if_start, buf_idx, buf_row);
endinterface

`default_nettype wire

/* rtl/load_config_regs.sv */
`default_nettype none

module load_config_regs import conv_load_pkg::*; (
  input logic clk,
  input logic reset,
  input logic mode_init,
  input idx_t of_init,
  input idx_t ox_init,
  input idx_t oy_init,
  input idx_t nif_init,
  input idx_t input_ddr_layer_base_adr_init,
  input log2_t nif_in_2pow_init,
  input log2_t ix_in_2pow_init,
  input size_t [2:0][2:0] split_size_init,
  input size_t [2:0] ix_word_num_init,
  input size_t [2:0] iy_row_num_init,
  input idx_t ix_chunks_num_init,
  input idx_t iy_chunks_num_init,
  layer_cfg_if.src cfg
);

  logic mode;
  log2_t nif_log2;
  log2_t ix_log2;
  log2_t buf_row_bits;

  // layer setup is sampled for as long as reset is held
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mode <= mode_init;
      nif_log2 <= nif_in_2pow_init;
      ix_log2 <= ix_in_2pow_init;
      cfg.of <= of_init;
      cfg.ox <= ox_init;
      cfg.oy <= oy_init;
      cfg.nif <= nif_init;
      cfg.base_adr <= input_ddr_layer_base_adr_init;
      cfg.split_size <= split_size_init;
      cfg.ix_word_num <= ix_word_num_init;
      cfg.iy_row_num <= iy_row_num_init;
      cfg.ix_chunks_num <= ix_chunks_num_init;
      cfg.iy_chunks_num <= iy_chunks_num_init;
    end
  end

  ////////////////////
  // derived fields
  ////////////////////

  // 64 filters per chunk in mode 0, 128 in mode 1
  assign cfg.row_num = mode ? idx_t'(ROW_NUM_MODE1) : idx_t'(ROW_NUM_MODE0);

  // words per column word, all input channels of 32 pixels
  assign cfg.col_shift = nif_log2 - log2_t'(IFS_IN_ROW_LOG2);
  // words per input row, ix/32 column words
  assign cfg.row_shift = cfg.col_shift + ix_log2 - log2_t'(PIXELS_IN_ROW_LOG2);

  // rows that fit in one buffer, the rest wrap around
  assign buf_row_bits = log2_t'(INPUT_BUFFER_SIZE_LOG2) - cfg.row_shift;
  assign cfg.row_mask = 16'hffff >> (5'd16 - {1'b0, buf_row_bits});

endmodule

`default_nettype wire

/* rtl/tile_sequencer.sv */
`default_nettype none

module tile_sequencer import conv_load_pkg::*; (
  input logic clk,
  input logic reset,
  input logic conv_load_input,
  layer_cfg_if.dst cfg,
  term_if.seq term,
  output logic conv_load_input_fin
);

  logic f_step;
  idx_t f_start;
  idx_t f_next;
  idx_t f_cur;
  logic chunk_last;
  logic term_last_chunk;
  logic tile_loaded;
  logic empty_term;
  logic tile_done;
  logic tile_adv;
  idx_t x_start;
  idx_t y_start;
  logic x_wrap;
  logic y_wrap;
  tile_class_e x_cls;
  tile_class_e y_cls;

  ////////////////////
  // output-channel chunks
  ////////////////////

  // chunk start moves one cycle after the request
  always_ff @(posedge clk)
  begin
    if (reset)
      f_step <= 1'b0;
    else
      f_step <= conv_load_input;
  end

  // next chunk start, back to 1 once past of
  assign f_next = ((f_start + cfg.row_num) > cfg.of) ? idx_t'(1) : f_start + cfg.row_num;

  always_ff @(posedge clk)
  begin
    if (reset)
      f_start <= idx_t'(1);
    else if (f_step)
      f_start <= f_next;
  end

  // a request right behind the step still sees the stepped chunk
  assign f_cur = f_step ? f_next : f_start;
  assign chunk_last = (f_cur + cfg.row_num) > cfg.of;

  ////////////////////
  // term control
  ////////////////////

  // tile already in the buffers, or nothing to load at all
  assign empty_term = conv_load_input && (tile_loaded || (term.chunk_words == '0));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      term.start <= 1'b0;
      term_last_chunk <= 1'b0;
    end
    else
    begin
      term.start <= conv_load_input && !empty_term;
      if (conv_load_input)
        term_last_chunk <= chunk_last;
    end
  end

  assign tile_done = term.word_done && term.tile_end;

  // tile moves on when its last channel chunk has been served
  assign tile_adv = (tile_done && term_last_chunk) || (empty_term && chunk_last);

  // whole tile read early, the remaining chunks need no loads
  always_ff @(posedge clk)
  begin
    if (reset)
      tile_loaded <= 1'b0;
    else if (tile_done && !term_last_chunk)
      tile_loaded <= 1'b1;
    else if (tile_adv)
      tile_loaded <= 1'b0;
  end

  assign conv_load_input_fin = (term.word_done && term.term_end) || empty_term;

  ////////////////////
  // tile x/y loop
  ////////////////////

  assign x_wrap = (x_start + idx_t'(PIXELS_IN_ROW)) > cfg.ox;
  assign y_wrap = (y_start + idx_t'(BUFFERS_NUM)) > cfg.oy;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      x_start <= idx_t'(1);
      y_start <= idx_t'(1);
    end
    else if (tile_adv)
    begin
      x_start <= x_wrap ? idx_t'(1) : x_start + idx_t'(PIXELS_IN_ROW);
      // row of tiles done, step down by the tile height
      if (x_wrap)
        y_start <= y_wrap ? idx_t'(1) : y_start + idx_t'(BUFFERS_NUM);
    end
  end

  // first tile wins over last when the layer is a single tile wide
  always_comb
  begin
    if (x_start == idx_t'(1))
      x_cls = FIRST;
    else if (x_wrap)
      x_cls = LAST;
    else
      x_cls = MID;
    if (y_start == idx_t'(1))
      y_cls = FIRST;
    else if (y_wrap)
      y_cls = LAST;
    else
      y_cls = MID;
  end

  // words of the whole tile, ix words times iy rows
  assign term.chunk_words = idx_t'(cfg.ix_word_num[x_cls]) * idx_t'(cfg.iy_row_num[y_cls]);
  assign term.split_size = cfg.split_size[y_cls][x_cls];

endmodule

`default_nettype wire

/* rtl/fetch_counter.sv */
`default_nettype none

module fetch_counter import conv_load_pkg::*; (
  input logic clk,
  input logic reset,
  input logic ddr_en,
  layer_cfg_if.dst cfg,
  term_if.fetch term,
  fetch_pos_if.src pos
);

  logic busy;
  logic active;
  idx_t term_cnt;
  idx_t tile_cnt;
  logic col_wrap;
  logic row_wrap;

  ////////////////////
  // read pacing
  ////////////////////

  // reads start in the cycle of the start pulse
  assign active = term.start || busy;
  // ddr_en low holds every counter below
  assign pos.read_en = active && ddr_en;

  always_ff @(posedge clk)
  begin
    if (reset)
      busy <= 1'b0;
    else if (term.term_end)
      busy <= 1'b0;
    else if (term.start)
      busy <= 1'b1;
  end

  // innermost loop, two input channels per read
  assign term.word_done = pos.read_en && ((pos.if_start + idx_t'(2)) > cfg.nif);

  always_ff @(posedge clk)
  begin
    if (reset)
      pos.if_start <= idx_t'(1);
    else if (pos.read_en)
      pos.if_start <= term.word_done ? idx_t'(1) : pos.if_start + idx_t'(2);
  end

  ////////////////////
  // word counters
  ////////////////////

  assign term.tile_end = term.word_done && (tile_cnt == term.chunk_words);
  // term stops at its split share or at the end of the tile
  assign term.term_end = term.word_done
                         && ((term_cnt == idx_t'(term.split_size))
                             || (tile_cnt == term.chunk_words));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      term_cnt <= idx_t'(1);
      tile_cnt <= idx_t'(1);
    end
    else if (term.word_done)
    begin
      term_cnt <= term.term_end ? idx_t'(1) : term_cnt + idx_t'(1);
      tile_cnt <= term.tile_end ? idx_t'(1) : tile_cnt + idx_t'(1);
    end
  end

  ////////////////////
  // column and row walk
  ////////////////////

  assign col_wrap = term.word_done && (pos.col_idx == cfg.ix_chunks_num);
  assign row_wrap = col_wrap && (pos.row_idx == cfg.iy_chunks_num);

  always_ff @(posedge clk)
  begin
    if (reset)
      pos.col_idx <= idx_t'(1);
    else if (term.word_done)
      pos.col_idx <= col_wrap ? idx_t'(1) : pos.col_idx + idx_t'(1);
  end

  // row buffers rotate 1, 2, 3, buffer row steps after buffer 3
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pos.row_idx <= idx_t'(1);
      pos.buf_idx <= buf_idx_t'(1);
      pos.buf_row <= '0;
    end
    else if (row_wrap)
    begin
      pos.row_idx <= idx_t'(1);
      pos.buf_idx <= buf_idx_t'(1);
      pos.buf_row <= '0;
    end
    else if (col_wrap)
    begin
      pos.row_idx <= pos.row_idx + idx_t'(1);
      pos.buf_idx <= (pos.buf_idx == buf_idx_t'(BUFFERS_NUM)) ? buf_idx_t'(1)
                                                               : pos.buf_idx + buf_idx_t'(1);
      if (pos.buf_idx == buf_idx_t'(BUFFERS_NUM))
        pos.buf_row <= pos.buf_row + idx_t'(1);
    end
  end

endmodule

`default_nettype wire

/* rtl/load_address_gen.sv */
`default_nettype none

module load_address_gen import conv_load_pkg::*; (
  layer_cfg_if.dst cfg,
  fetch_pos_if.dst pos,
  output logic input_word_ddr_en_rd,
  output logic input_word_load_info_fifo_en_wt,
  output idx_t input_word_ddr_adr_rd,
  output idx_t load_input_row_idx,
  output idx_t load_input_row_start_idx,
  output idx_t load_input_if_idx,
  output load_info_t input_word_load_info_fifo_wt
);

  idx_t col_off;
  idx_t if_off;
  idx_t buf_adr;

  // column word and channel pair offsets, shared by ddr and buffer
  assign col_off = (pos.col_idx - idx_t'(1)) << cfg.col_shift;
  assign if_off = (pos.if_start - idx_t'(1)) >> IFS_IN_ROW_LOG2;

  // ddr address walks the full input rows of the layer
  assign input_word_ddr_adr_rd = cfg.base_adr + ((pos.row_idx - idx_t'(1)) << cfg.row_shift)
                                 + col_off + if_off;

  // buffer address uses the row inside its buffer, wrapped to the depth
  assign buf_adr = ((pos.buf_row & cfg.row_mask) << cfg.row_shift) + col_off + if_off;

  assign load_input_row_idx = pos.row_idx;
  // first pixel of the column word
  assign load_input_row_start_idx = ((pos.col_idx - idx_t'(1)) << PIXELS_IN_ROW_LOG2) + idx_t'(1);
  assign load_input_if_idx = pos.if_start;

  // one info word goes with every read
  assign input_word_ddr_en_rd = pos.read_en;
  assign input_word_load_info_fifo_en_wt = pos.read_en;
  assign input_word_load_info_fifo_wt = '{buf_idx: pos.buf_idx, buf_adr: 30'(buf_adr)};

endmodule

`default_nettype wire

/* rtl/conv_load_input_controller.sv */
`default_nettype none

module conv_load_input_controller import conv_load_pkg::*; (
  input logic clk,
  input logic reset,
  input logic conv_load_input,
  input logic ddr_en,
  // layer setup, sampled while reset is high
  input logic mode_init,
  input idx_t of_init,
  input idx_t ox_init,
  input idx_t oy_init,
  input idx_t nif_init,
  input idx_t input_ddr_layer_base_adr_init,
  input log2_t nif_in_2pow_init,
  input log2_t ix_in_2pow_init,
  input size_t [2:0][2:0] split_size_init,
  input size_t [2:0] ix_word_num_init,
  input size_t [2:0] iy_row_num_init,
  input idx_t ix_chunks_num_init,
  input idx_t iy_chunks_num_init,
  // ddr reads and fifo writes
  output logic input_word_ddr_en_rd,
  output logic input_word_load_info_fifo_en_wt,
  output idx_t input_word_ddr_adr_rd,
  output idx_t load_input_row_idx,
  output idx_t load_input_row_start_idx,
  output idx_t load_input_if_idx,
  output load_info_t input_word_load_info_fifo_wt,
  output logic conv_load_input_fin
);

  layer_cfg_if cfg_if ();
  term_if term_bus ();
  fetch_pos_if pos_bus ();

  load_config_regs cfg_regs0 (
    .clk(clk),
    .reset(reset),
    .mode_init(mode_init),
    .of_init(of_init),
    .ox_init(ox_init),
    .oy_init(oy_init),
    .nif_init(nif_init),
    .input_ddr_layer_base_adr_init(input_ddr_layer_base_adr_init),
    .nif_in_2pow_init(nif_in_2pow_init),
    .ix_in_2pow_init(ix_in_2pow_init),
    .split_size_init(split_size_init),
    .ix_word_num_init(ix_word_num_init),
    .iy_row_num_init(iy_row_num_init),
    .ix_chunks_num_init(ix_chunks_num_init),
    .iy_chunks_num_init(iy_chunks_num_init),
    .cfg(cfg_if)
  );

  // tile and chunk loop, runs beside the fetch loop
  tile_sequencer seq0 (
    .clk(clk),
    .reset(reset),
    .conv_load_input(conv_load_input),
    .cfg(cfg_if),
    .term(term_bus),
    .conv_load_input_fin(conv_load_input_fin)
  );

  fetch_counter fetch0 (
    .clk(clk),
    .reset(reset),
    .ddr_en(ddr_en),
    .cfg(cfg_if),
    .term(term_bus),
    .pos(pos_bus)
  );

  load_address_gen adr0 (
    .cfg(cfg_if),
    .pos(pos_bus),
    .input_word_ddr_en_rd(input_word_ddr_en_rd),
    .input_word_load_info_fifo_en_wt(input_word_load_info_fifo_en_wt),
    .input_word_ddr_adr_rd(input_word_ddr_adr_rd),
    .load_input_row_idx(load_input_row_idx),
    .load_input_row_start_idx(load_input_row_start_idx),
    .load_input_if_idx(load_input_if_idx),
    .input_word_load_info_fifo_wt(input_word_load_info_fifo_wt)
  );

endmodule

`default_nettype wire

/* test/tb_conv_load.sv */
`default_nettype none

module tb_conv_load import conv_load_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // test setup
  ////////////////////

  // one tile per layer, 2 column words by 3 rows, two chunks of 64 filters
  localparam int NIF = 8;
  localparam int NIF_LOG2 = 3;
  localparam int IX_LOG2 = 6;
  localparam int IXC = 2;
  localparam int IYC = 3;
  localparam int SPLIT = 4;
  localparam int BASE = 'h100;
  localparam int NUM_TERMS = 8;
  localparam int NUM_EMPTY = 3;
  // a tile costs 6 words of 4 reads over two terms
  localparam int TOTAL_READS = (NUM_TERMS / 2) * IXC * IYC * ((NIF + 1) / 2);
  localparam int CYCLE_LIMIT = 2 * TOTAL_READS + 400;
  localparam logic [31:0] SEED = 32'haf0a;

  logic clk;
  logic reset;
  logic conv_load_input;
  logic ddr_en;
  idx_t of_init, ox_init, oy_init, nif_init, base_init;
  log2_t nif_log2_init, ix_log2_init;
  size_t [2:0][2:0] split_init;
  size_t [2:0] ix_words_init;
  size_t [2:0] iy_rows_init;
  idx_t ix_chunks_init, iy_chunks_init;

  logic rd, fifo_en, fin;
  idx_t adr, row_idx, row_start, if_idx;
  load_info_t info;

  conv_load_input_controller dut0 (
    .clk(clk), .reset(reset), .conv_load_input(conv_load_input), .ddr_en(ddr_en),
    .mode_init(1'b0), .of_init(of_init), .ox_init(ox_init), .oy_init(oy_init),
    .nif_init(nif_init), .input_ddr_layer_base_adr_init(base_init),
    .nif_in_2pow_init(nif_log2_init), .ix_in_2pow_init(ix_log2_init),
    .split_size_init(split_init), .ix_word_num_init(ix_words_init),
    .iy_row_num_init(iy_rows_init), .ix_chunks_num_init(ix_chunks_init),
    .iy_chunks_num_init(iy_chunks_init),
    .input_word_ddr_en_rd(rd), .input_word_load_info_fifo_en_wt(fifo_en),
    .input_word_ddr_adr_rd(adr), .load_input_row_idx(row_idx),
    .load_input_row_start_idx(row_start), .load_input_if_idx(if_idx),
    .input_word_load_info_fifo_wt(info), .conv_load_input_fin(fin)
  );

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] lfsr = SEED;
  // model state, channel pair innermost, then column, then row
  int m_row, m_col, m_if, m_term, m_tile, m_tile_start, m_reads, cw_model;
  int col_sh, row_sh, exp_adr, exp_badr, exp_reads, remaining;
  logic started, term_done, wd, te, exp_fin;
  idx_t prev_adr, prev_if, prev_row;
  // previous cycle was stalled outside reset
  logic prev_stall = 1'b0;

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("FAIL %0d ns: %s", $time, msg);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ddr stalls about one cycle in four
  always @(posedge clk)
  begin
    logic b0, b1;
    lfsr = lfsr_next(lfsr);
    b0 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1 = lfsr[0];
    ddr_en <= b0 | b1;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: no finish after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////
  // reference model and checks
  ////////////////////

  always @(negedge clk)
  begin
    col_sh = NIF_LOG2 - 1;
    row_sh = col_sh + IX_LOG2 - 5;
    checks++;
    // nothing moves before the first request, an empty request may finish at once
    assert (!(reset || !started) || (!rd && !fifo_en && (!fin || conv_load_input)))
      else report_fail("read, fifo write or finish before the first request");
    if (reset)
    begin
      m_row = 1;
      m_col = 1;
      m_if = 1;
      m_term = 1;
      m_tile = 1;
      m_reads = 0;
      started = 1'b0;
    end
    else
    begin
      if (conv_load_input)
      begin
        started = 1'b1;
        m_reads = 0;
        m_tile_start = m_tile;
      end
      // stalled cycle issues no read
      if (!ddr_en)
      begin
        checks++;
        assert (!rd) else report_fail("read issued while ddr_en was low");
      end
      // a stall leaves the position where it was
      if (prev_stall)
      begin
        checks++;
        assert (adr == prev_adr && if_idx == prev_if && row_idx == prev_row)
          else report_fail("outputs moved while ddr_en was low");
      end
      checks++;
      assert (fifo_en == rd) else report_fail("fifo write not paired with a read");
      wd = (m_if + 2) > NIF;
      te = wd && (m_term == SPLIT || m_tile == cw_model);
      exp_fin = (rd && te) || (conv_load_input && cw_model == 0);
      if (rd)
      begin
        exp_adr = BASE + ((m_row - 1) << row_sh) + ((m_col - 1) << col_sh) + ((m_if - 1) >> 1);
        exp_badr = ((((m_row - 1) / 3) & 'h1ff) << row_sh) + ((m_col - 1) << col_sh)
                   + ((m_if - 1) >> 1);
        checks += 3;
        assert (int'(adr) == exp_adr && int'(if_idx) == m_if && int'(row_idx) == m_row)
          else report_fail($sformatf("ddr address %0h if %0d, model %0h if %0d",
                                     adr, if_idx, exp_adr, m_if));
        assert (int'(info.buf_idx) == ((m_row - 1) % 3) + 1 && int'(info.buf_adr) == exp_badr)
          else report_fail($sformatf("info word %0h, model buffer %0d address %0h",
                                     info, ((m_row - 1) % 3) + 1, exp_badr));
        assert (int'(row_start) == (m_col - 1) * 32 + 1)
          else report_fail($sformatf("row start %0d for column %0d", row_start, m_col));
        m_reads++;
        if (wd)
        begin
          m_if = 1;
          m_term = te ? 1 : m_term + 1;
          m_tile = (m_tile == cw_model) ? 1 : m_tile + 1;
          if (m_col == IXC)
          begin
            m_col = 1;
            m_row = (m_row == IYC) ? 1 : m_row + 1;
          end
          else
            m_col++;
        end
        else
          m_if += 2;
      end
      checks++;
      assert (fin == exp_fin)
        else report_fail($sformatf("finish %0b, model %0b", fin, exp_fin));
      if (fin)
      begin
        remaining = cw_model - m_tile_start + 1;
        exp_reads = ((NIF + 1) / 2) * ((SPLIT < remaining) ? SPLIT : remaining);
        checks++;
        assert (m_reads == exp_reads)
          else report_fail($sformatf("term read %0d words, model %0d", m_reads, exp_reads));
        term_done = 1'b1;
      end
    end
    prev_adr = adr;
    prev_if = if_idx;
    prev_row = row_idx;
    prev_stall = !reset && !ddr_en;
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic run_term();
    @(posedge clk);
    term_done = 1'b0;
    conv_load_input <= 1'b1;
    @(posedge clk);
    conv_load_input <= 1'b0;
    while (!term_done)
      @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  initial
  begin
    reset = 1'b1;
    conv_load_input = 1'b0;
    ddr_en = 1'b1;
    of_init = 16'd128;
    ox_init = 16'd32;
    oy_init = 16'd3;
    nif_init = 16'(NIF);
    base_init = 16'(BASE);
    nif_log2_init = 4'(NIF_LOG2);
    ix_log2_init = 4'(IX_LOG2);
    split_init = '{default: 8'(SPLIT)};
    ix_words_init = '{default: 8'(IXC)};
    iy_rows_init = '{default: 8'(IYC)};
    ix_chunks_init = 16'(IXC);
    iy_chunks_init = 16'(IYC);
    cw_model = IXC * IYC;
    term_done = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_TERMS; i++)
      run_term();
    // second layer with nothing to load
    @(posedge clk);
    reset <= 1'b1;
    ix_words_init <= '{default: 8'd0};
    cw_model = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    for (int i = 0; i < NUM_EMPTY; i++)
      run_term();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* conv_load_input_controller.f */
rtl/conv_load_pkg.sv
rtl/conv_load_if.sv
rtl/load_config_regs.sv
rtl/tile_sequencer.sv
rtl/fetch_counter.sv
rtl/load_address_gen.sv
rtl/conv_load_input_controller.sv
test/tb_conv_load.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f conv_load_input_controller.f \
  --top-module tb_conv_load -Mdir obj_dir -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "PASS: all tests" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
